//--- hood_timer_top.f
src/hood_pkg.sv
src/disp_pkg.sv
src/panel_input.sv
src/usage_timer.sv
src/boost_timer.sv
src/reminder_set.sv
src/display_select.sv
src/seg_scan.sv
src/hood_timer_top.sv
testbench/hood_timer_props.sv
testbench/hood_timer_tb.sv

//--- Makefile
BIN  := obj_dir/Vhood_timer_tb
SRCS := $(wildcard src/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): hood_timer_top.f $(SRCS)
	verilator --binary --timing --assert --top-module hood_timer_tb -f hood_timer_top.f

run: $(BIN)
	./$(BIN) | awk '{ print } /Regression passed/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

//--- testbench/hood_timer_tb.sv
`timescale 1ns/1ns

module hood_timer_tb
    import hood_pkg::*;
    import disp_pkg::*;
();

    localparam int TICK_BUDGET = 560;                    // summed ticks of all tests
    localparam int CYCLE_LIMIT = 2 * TICK_BUDGET * TICK_DIV;
    localparam int VIEW_USAGE  = 0;
    localparam int VIEW_BOOST  = 1;
    localparam int VIEW_REMIND = 2;

    logic       clk, rst, menu_btn, hand_clean, machine_state;
    logic [2:0] mode_state;
    logic [3:0] btn;
    logic [7:0] seg, tube_sel;
    logic       return_state, boost_enabled, menu_pressed, need_clean;

    // reference model state
    int   usage_s, boost_left, m_hr, m_min, m_sec, m_pos;
    logic m_boost_en, m_menu, m_ret, m_adj;
    int   tests = 0, checks = 0, fails = 0, test_fails = 0, cycles = 0;
    logic [31:0] rng;

    hood_timer_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    ////////////////////////////////////////////////////
    // expected display word for a view
    function automatic disp_word_t expected_word(input int view);
        disp_word_t w;
        int h, m, s;
        case (view)
            VIEW_BOOST: begin
                h = 0;
                m = boost_left / 60;
                s = boost_left % 60;
            end
            VIEW_REMIND: begin
                h = m_hr;
                m = m_min;
                s = m_sec;
            end
            default: begin
                h = (usage_s / 3600) % 24;
                m = (usage_s / 60) % 60;
                s = usage_s % 60;
            end
        endcase
        w.fields.hr_tens   = 4'(h / 10);
        w.fields.hr_units  = 4'(h % 10);
        w.fields.sep_hm    = 4'hf;
        w.fields.min_tens  = 4'(m / 10);
        w.fields.min_units = 4'(m % 10);
        w.fields.sep_ms    = 4'hf;
        w.fields.sec_tens  = 4'(s / 10);
        w.fields.sec_units = 4'(s % 10);
        return w;
    endfunction

    function automatic logic [3:0] seg_to_code(input logic [7:0] p);
        case (p)
            8'h3f: return 4'd0;
            8'h06: return 4'd1;
            8'h5b: return 4'd2;
            8'h4f: return 4'd3;
            8'h66: return 4'd4;
            8'h6d: return 4'd5;
            8'h7d: return 4'd6;
            8'h07: return 4'd7;
            8'h7f: return 4'd8;
            8'h6f: return 4'd9;
            8'h40: return 4'hf;                          // dash
            default: return 4'he;                        // unknown pattern
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            fails++;
            test_fails++;
            $display("[FAIL] %s expected %h got %h", name, exp, act);
        end
    endtask

    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // next drive lands just after a tick edge
    task automatic align_tick();
        @(negedge clk);
        while (!dut_i.panel_i.tick) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic run_ticks(input int n, input logic [2:0] mode);
        align_tick();
        mode_state = mode;
        step(n * TICK_DIV);
        mode_state = MODE_IDLE;
    endtask

    task automatic model_boost(input int n);
        repeat (n) begin
            if (m_boost_en && boost_left == 0) begin
                m_boost_en = 1'b0;
                m_ret      = !m_menu;
            end else if (m_boost_en) begin
                boost_left--;
            end
        end
    endtask

    task automatic model_power_on();
        boost_left = BOOST_MIN * 60;
        m_boost_en = 1'b1;
        m_menu     = 1'b0;
        m_ret      = 1'b0;
        m_hr       = REMIND_HR_RESET;
        m_min      = 0;
        m_sec      = 0;
        m_adj      = 1'b0;
        m_pos      = 0;
    endtask

    task automatic press(input int b);
        int amt, lim, v;
        btn[b] = 1'b1;
        step(3 * TICK_DIV);
        btn[b] = 1'b0;
        step(8);
        amt = (m_pos % 2 == 1) ? 10 : 1;
        lim = (m_pos / 2 == 2) ? HR_LIMIT : 60;
        v   = (m_pos / 2 == 0) ? m_sec : (m_pos / 2 == 1) ? m_min : m_hr;
        if (b == BTN_DOWN && machine_state) begin
            m_adj = !m_adj;
        end else if (m_adj && b == BTN_UP) begin
            m_pos = (m_pos + 1) % 6;
        end else if (m_adj && (b == BTN_LEFT || b == BTN_RIGHT)) begin
            v = (b == BTN_RIGHT) ? (v + amt) % lim : (v - amt + lim) % lim;
            if (m_pos / 2 == 0) m_sec = v;
            else if (m_pos / 2 == 1) m_min = v;
            else m_hr = v;
        end
    endtask

    // decode one full scan and compare with the model
    task automatic check_display(input int view);
        disp_word_t got;
        int idx;
        int hits [DIGITS];
        got = '0;
        for (int j = 0; j < DIGITS; j++)
            hits[j] = 0;
        repeat (3) @(posedge clk);
        for (int i = 0; i < DIGITS * SCAN_DIV; i++) begin
            @(negedge clk);
            idx = 0;
            for (int j = 0; j < DIGITS; j++)
                if (tube_sel[j]) idx = j;
            hits[idx]++;
            got.digit[idx] = seg_to_code(seg);
        end
        step(1);
        check_value("seg", expected_word(view), got);
        // every digit lit for SCAN_DIV clocks in one full scan
        for (int j = 0; j < DIGITS; j++)
            check_value($sformatf("tube_sel[%0d] scan count", j), SCAN_DIV, hits[j]);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %s", tests, name, (test_fails == 0) ? "ok" : "mismatches");
        test_fails = 0;
    endtask

    initial begin
        int n;
        rst           = 1'b0;
        mode_state    = MODE_IDLE;
        menu_btn      = 1'b0;
        hand_clean    = 1'b0;
        btn           = '0;
        machine_state = 1'b0;
        rng = 32'h3250_0a3e;
        usage_s = 0;
        model_power_on();
        repeat (4) @(posedge clk);
        #1 rst = 1'b1;
        machine_state = 1'b1;
        step(3);

        //////////////////////////////////////////////////
        // usage time
        rng = xorshift32(rng);
        n   = int'(rng % 200) + 1;
        run_ticks(n, rng[8] ? MODE_HIGH : MODE_LOW);
        usage_s += n;
        check_display(VIEW_USAGE);
        run_ticks(5, MODE_IDLE);                         // idle adds nothing
        check_display(VIEW_USAGE);
        hand_clean = 1'b1;
        step(1);
        hand_clean = 1'b0;
        usage_s = 0;
        check_display(VIEW_USAGE);
        end_test("usage time");

        // boost countdown
        align_tick();
        mode_state = MODE_BOOST;
        step(1);
        mode_state = MODE_IDLE;
        check_display(VIEW_BOOST);
        run_ticks(61, MODE_BOOST);
        model_boost(61);
        check_value("boost_enabled", m_boost_en, boost_enabled);
        check_value("return_state", m_ret, return_state);
        check_display(VIEW_BOOST);
        run_ticks(5, MODE_BOOST);
        model_boost(5);
        check_value("boost_enabled", m_boost_en, boost_enabled);
        check_display(VIEW_BOOST);
        end_test("boost");

        // re-arm and menu
        machine_state = 1'b0;
        step(2);
        machine_state = 1'b1;
        step(3);
        model_power_on();
        check_value("boost_enabled", m_boost_en, boost_enabled);
        check_value("return_state", m_ret, return_state);
        align_tick();
        mode_state = MODE_BOOST;
        menu_btn   = 1'b1;
        step(1);
        menu_btn = 1'b0;
        m_menu   = 1'b1;
        step(61 * TICK_DIV - 1);
        mode_state = MODE_IDLE;
        model_boost(61);
        check_value("menu_pressed", m_menu, menu_pressed);
        check_value("return_state", m_ret, return_state);
        check_value("boost_enabled", m_boost_en, boost_enabled);
        check_display(VIEW_BOOST);
        end_test("menu and re-arm");

        // threshold editing
        mode_state = MODE_SHOW_REMIND;
        step(1);
        press(BTN_DOWN);
        repeat (5) press(BTN_UP);
        press(BTN_LEFT);
        repeat (3) press(BTN_UP);
        press(BTN_RIGHT);
        check_display(VIEW_REMIND);
        press(BTN_LEFT);
        press(BTN_LEFT);                                 // 0 wraps to 59
        check_display(VIEW_REMIND);
        press(BTN_RIGHT);
        press(BTN_RIGHT);
        check_display(VIEW_REMIND);
        end_test("threshold editing");

        // cleaning flag
        mode_state = MODE_IDLE;
        step(2);
        check_value("need_clean", 0, need_clean);
        run_ticks(59, MODE_LOW);
        usage_s += 59;
        step(1);
        check_value("need_clean", usage_s >= m_hr * 3600 + m_min * 60 + m_sec, need_clean);
        run_ticks(1, MODE_LOW);
        usage_s += 1;
        step(1);
        check_value("need_clean", usage_s >= m_hr * 3600 + m_min * 60 + m_sec, need_clean);
        machine_state = 1'b0;
        step(1);
        check_value("need_clean", 0, need_clean);
        end_test("cleaning flag");

        $display("tests %0d, checks %0d, failures %0d", tests, checks, fails);
        if (fails == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

//--- testbench/hood_timer_props.sv
`timescale 1ns/1ns

module hood_timer_props (
    input logic       clk,
    input logic       rst,
    input logic [7:0] tube_sel,
    input logic       machine_state,
    input logic       need_clean,
    input logic       boost_enabled,
    input logic       return_state
);

    // exactly one digit lit at a time
    a_tube_onehot: assert property (@(posedge clk) disable iff (!rst) $onehot(tube_sel))
        else $error("tube_sel is not one-hot");

    a_need_clean_running: assert property (@(posedge clk) disable iff (!rst)
        need_clean |-> $past(machine_state))
        else $error("need_clean high without machine_state");

    // power-on pulse sits between the machine_state edge and the re-arm
    a_boost_rearm: assert property (@(posedge clk) disable iff (!rst)
        $rose(boost_enabled) |-> $past(machine_state, 2) && !$past(machine_state, 3))
        else $error("boost_enabled rose without a power-on");

    a_return_state: assert property (@(posedge clk) disable iff (!rst)
        $changed(return_state) |-> $fell(boost_enabled) || $rose(boost_enabled))
        else $error("return_state changed outside a boost end or re-arm");

endmodule

bind hood_timer_top hood_timer_props props_i (.*);

//--- src/hood_timer_top.sv
`timescale 1ns/1ns

module hood_timer_top
    import hood_pkg::*;
    import disp_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] mode_state,
    input  logic       menu_btn,
    input  logic       hand_clean,
    input  logic [3:0] btn,
    input  logic       machine_state,
    output logic [7:0] seg,
    output logic [7:0] tube_sel,
    output logic       return_state,
    output logic       boost_enabled,
    output logic       menu_pressed,
    output logic       need_clean
);

    logic               tick;
    logic [3:0]         btn_rise;
    logic               power_on_rise;
    logic [HR_W-1:0]    usage_hr;
    logic [FIELD_W-1:0] usage_min;
    logic [FIELD_W-1:0] usage_sec;
    logic [FIELD_W-1:0] boost_min;
    logic [FIELD_W-1:0] boost_sec;
    logic [HR_W-1:0]    rem_hr;
    logic [FIELD_W-1:0] rem_min;
    logic [FIELD_W-1:0] rem_sec;
    disp_word_t         disp_word;

    //////////////////////////////////////////////////
    // panel and time sources
    panel_input panel_i (
        .clk(clk), .rst(rst), .btn(btn), .machine_state(machine_state),
        .tick(tick), .btn_rise(btn_rise), .power_on_rise(power_on_rise)
    );

    usage_timer usage_i (
        .clk(clk), .rst(rst), .tick(tick), .mode_state(mode_state),
        .hand_clean(hand_clean),
        .usage_hr(usage_hr), .usage_min(usage_min), .usage_sec(usage_sec)
    );

    boost_timer boost_i (
        .clk(clk), .rst(rst), .tick(tick), .mode_state(mode_state),
        .menu_btn(menu_btn), .power_on_rise(power_on_rise),
        .boost_min(boost_min), .boost_sec(boost_sec),
        .boost_enabled(boost_enabled), .menu_pressed(menu_pressed),
        .return_state(return_state)
    );

    reminder_set remind_i (
        .clk(clk), .rst(rst), .btn_rise(btn_rise),
        .machine_state(machine_state), .power_on_rise(power_on_rise),
        .usage_hr(usage_hr), .usage_min(usage_min), .usage_sec(usage_sec),
        .rem_hr(rem_hr), .rem_min(rem_min), .rem_sec(rem_sec),
        .need_clean(need_clean)
    );

    // display path
    display_select select_i (
        .clk(clk), .rst(rst), .mode_state(mode_state),
        .usage_hr(usage_hr), .usage_min(usage_min), .usage_sec(usage_sec),
        .boost_min(boost_min), .boost_sec(boost_sec),
        .rem_hr(rem_hr), .rem_min(rem_min), .rem_sec(rem_sec),
        .disp_word(disp_word)
    );

    seg_scan scan_i (
        .clk(clk), .rst(rst), .disp_word(disp_word),
        .seg(seg), .tube_sel(tube_sel)
    );

endmodule

//--- src/seg_scan.sv
`timescale 1ns/1ns

module seg_scan
    import disp_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  disp_word_t        disp_word,
    output logic [7:0]        seg,
    output logic [DIGITS-1:0] tube_sel
);

    logic [SCAN_W-1:0]  scan_cnt;
    logic [DIGIT_W-1:0] digit_idx;

    //////////////////////////////////////////////////
    // digit rotation
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == SCAN_W'(SCAN_DIV - 1)) begin
            scan_cnt <= '0;
            if (digit_idx == DIGIT_W'(DIGITS - 1))
                digit_idx <= '0;
            else
                digit_idx <= digit_idx + 1'b1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    // enable and pattern both come from the same index
    assign tube_sel = DIGITS'(1) << digit_idx;
    assign seg      = seg_lookup(disp_word.digit[digit_idx]);  // dp stays off

endmodule

//--- src/display_select.sv
`timescale 1ns/1ns

module display_select
    import hood_pkg::*;
    import disp_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [2:0]         mode_state,
    input  logic [HR_W-1:0]    usage_hr,
    input  logic [FIELD_W-1:0] usage_min,
    input  logic [FIELD_W-1:0] usage_sec,
    input  logic [FIELD_W-1:0] boost_min,
    input  logic [FIELD_W-1:0] boost_sec,
    input  logic [HR_W-1:0]    rem_hr,
    input  logic [FIELD_W-1:0] rem_min,
    input  logic [FIELD_W-1:0] rem_sec,
    output disp_word_t         disp_word
);

    logic [1:0] src;
    disp_word_t usage_word;
    disp_word_t boost_word;
    disp_word_t rem_word;

    function automatic disp_word_t to_word(input logic [HR_W-1:0]    hr,
                                           input logic [FIELD_W-1:0] mn,
                                           input logic [FIELD_W-1:0] sc);
        disp_word_t w;
        w.fields.hr_tens   = 4'(hr / 10);
        w.fields.hr_units  = 4'(hr % 10);
        w.fields.sep_hm    = SEP_CODE;
        w.fields.min_tens  = 4'(mn / 10);
        w.fields.min_units = 4'(mn % 10);
        w.fields.sep_ms    = SEP_CODE;
        w.fields.sec_tens  = 4'(sc / 10);
        w.fields.sec_units = 4'(sc % 10);
        return w;
    endfunction

    assign usage_word = to_word(usage_hr, usage_min, usage_sec);
    assign boost_word = to_word(HR_W'(0), boost_min, boost_sec);  // countdown shows 00 hours
    assign rem_word   = to_word(rem_hr, rem_min, rem_sec);

    // mode picks who owns the display
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            src <= SRC_USAGE;
        end else begin
            case (mode_state)
                MODE_LOW, MODE_HIGH: src <= SRC_USAGE;
                MODE_BOOST:          src <= SRC_BOOST;
                MODE_SHOW_REMIND:    src <= SRC_REMIND;
                MODE_IDLE:           src <= src;   // idle keeps the last view
                default:             src <= src;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (src)
            SRC_BOOST:  disp_word <= boost_word;
            SRC_REMIND: disp_word <= rem_word;
            default:    disp_word <= usage_word;
        endcase
    end

endmodule

//--- src/reminder_set.sv
`timescale 1ns/1ns

module reminder_set
    import hood_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [3:0]         btn_rise,
    input  logic               machine_state,
    input  logic               power_on_rise,
    input  logic [HR_W-1:0]    usage_hr,
    input  logic [FIELD_W-1:0] usage_min,
    input  logic [FIELD_W-1:0] usage_sec,
    output logic [HR_W-1:0]    rem_hr,
    output logic [FIELD_W-1:0] rem_min,
    output logic [FIELD_W-1:0] rem_sec,
    output logic               need_clean
);

    logic               adjust;
    logic [2:0]         pos;        // 0 is second units, 5 is hour tens
    logic [1:0]         fsel;
    logic [6:0]         step;
    logic [6:0]         limit;
    logic [6:0]         cur;
    logic [6:0]         inc_val;
    logic [6:0]         dec_val;
    logic [6:0]         new_val;
    logic [TOTAL_W-1:0] usage_total;
    logic [TOTAL_W-1:0] rem_total;

    function automatic logic [TOTAL_W-1:0] to_seconds(input logic [HR_W-1:0]    hr,
                                                      input logic [FIELD_W-1:0] mn,
                                                      input logic [FIELD_W-1:0] sc);
        return TOTAL_W'(hr) * TOTAL_W'(SEC_LIMIT * MIN_LIMIT)
             + TOTAL_W'(mn) * TOTAL_W'(SEC_LIMIT)
             + TOTAL_W'(sc);
    endfunction

    //////////////////////////////////////////////////
    // selected field and its wrapped neighbours
    assign fsel = pos[2:1];                 // 0 sec, 1 min, 2 hr
    assign step = pos[0] ? 7'd10 : 7'd1;    // odd positions are tens

    always_comb begin
        case (fsel)
            2'd0: begin
                cur   = 7'(rem_sec);
                limit = 7'(SEC_LIMIT);
            end
            2'd1: begin
                cur   = 7'(rem_min);
                limit = 7'(MIN_LIMIT);
            end
            default: begin
                cur   = 7'(rem_hr);
                limit = 7'(HR_LIMIT);
            end
        endcase
    end

    // each field wraps on its own, no carry
    assign inc_val = (cur + step >= limit) ? cur + step - limit : cur + step;
    assign dec_val = (cur < step) ? cur + limit - step : cur - step;
    assign new_val = btn_rise[BTN_RIGHT] ? inc_val : dec_val;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rem_hr  <= HR_W'(REMIND_HR_RESET);
            rem_min <= '0;
            rem_sec <= '0;
            adjust  <= 1'b0;
            pos     <= '0;
        end else if (power_on_rise) begin
            rem_hr  <= HR_W'(REMIND_HR_RESET);
            rem_min <= '0;
            rem_sec <= '0;
            adjust  <= 1'b0;
            pos     <= '0;
        end else begin
            if (btn_rise[BTN_DOWN] && machine_state)
                adjust <= ~adjust;

            if (adjust) begin
                if (btn_rise[BTN_UP])
                    pos <= (pos == 3'd5) ? 3'd0 : pos + 3'd1;

                if (btn_rise[BTN_RIGHT] || btn_rise[BTN_LEFT]) begin
                    case (fsel)
                        2'd0:    rem_sec <= FIELD_W'(new_val);
                        2'd1:    rem_min <= FIELD_W'(new_val);
                        default: rem_hr  <= HR_W'(new_val);
                    endcase
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // cleaning flag
    assign usage_total = to_seconds(usage_hr, usage_min, usage_sec);
    assign rem_total   = to_seconds(rem_hr, rem_min, rem_sec);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            need_clean <= 1'b0;
        else
            need_clean <= machine_state && (usage_total >= rem_total);
    end

endmodule

//--- src/boost_timer.sv
`timescale 1ns/1ns

module boost_timer
    import hood_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               tick,
    input  logic [2:0]         mode_state,
    input  logic               menu_btn,
    input  logic               power_on_rise,
    output logic [FIELD_W-1:0] boost_min,
    output logic [FIELD_W-1:0] boost_sec,
    output logic               boost_enabled,
    output logic               menu_pressed,
    output logic               return_state
);

    logic active;
    logic at_zero;

    assign active  = (mode_state == MODE_BOOST) && boost_enabled;
    assign at_zero = (boost_min == '0) && (boost_sec == '0);

    //////////////////////////////////////////////////
    // one-shot countdown, re-armed only by power-on
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            boost_min     <= FIELD_W'(BOOST_MIN);
            boost_sec     <= '0;
            boost_enabled <= 1'b1;
            menu_pressed  <= 1'b0;
            return_state  <= 1'b0;
        end else if (power_on_rise) begin
            boost_min     <= FIELD_W'(BOOST_MIN);
            boost_sec     <= '0;
            boost_enabled <= 1'b1;
            menu_pressed  <= 1'b0;
            return_state  <= 1'b0;
        end else if (active) begin
            if (menu_btn)
                menu_pressed <= 1'b1;       // user wants idle at the end

            if (tick) begin
                if (at_zero) begin
                    // spent, countdown holds from here on
                    boost_enabled <= 1'b0;
                    return_state  <= ~menu_pressed;
                end else if (boost_sec == '0) begin
                    boost_min <= boost_min - 1'b1;
                    boost_sec <= FIELD_W'(SEC_LIMIT - 1);
                end else begin
                    boost_sec <= boost_sec - 1'b1;
                end
            end
        end
    end

endmodule

//--- src/usage_timer.sv
`timescale 1ns/1ns

module usage_timer
    import hood_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               tick,
    input  logic [2:0]         mode_state,
    input  logic               hand_clean,
    output logic [HR_W-1:0]    usage_hr,
    output logic [FIELD_W-1:0] usage_min,
    output logic [FIELD_W-1:0] usage_sec
);

    logic running;

    // only the fan speeds count as use, boost does not
    assign running = (mode_state == MODE_LOW) || (mode_state == MODE_HIGH);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            usage_hr  <= '0;
            usage_min <= '0;
            usage_sec <= '0;
        end else if (hand_clean) begin      // manual clean wins over the tick
            usage_hr  <= '0;
            usage_min <= '0;
            usage_sec <= '0;
        end else if (tick && running) begin
            if (usage_sec == FIELD_W'(SEC_LIMIT - 1)) begin
                usage_sec <= '0;
                if (usage_min == FIELD_W'(MIN_LIMIT - 1)) begin
                    usage_min <= '0;
                    if (usage_hr == HR_W'(HR_LIMIT - 1))
                        usage_hr <= '0;     // wraps after a day
                    else
                        usage_hr <= usage_hr + 1'b1;
                end else begin
                    usage_min <= usage_min + 1'b1;
                end
            end else begin
                usage_sec <= usage_sec + 1'b1;
            end
        end
    end

endmodule

//--- src/panel_input.sv
`timescale 1ns/1ns

module panel_input
    import hood_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] btn,
    input  logic       machine_state,
    output logic       tick,
    output logic [3:0] btn_rise,
    output logic       power_on_rise
);

    logic [TICK_W-1:0] tick_cnt;
    logic [3:0]        btn_s1;
    logic [3:0]        btn_s2;
    logic [3:0]        btn_s3;
    logic              ms_prev;

    //////////////////////////////////////////////////
    // one second prescaler
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tick_cnt <= '0;
            tick     <= 1'b0;
        end else begin
            tick <= (tick_cnt == TICK_W'(TICK_DIV - 1));
            if (tick_cnt == TICK_W'(TICK_DIV - 1))
                tick_cnt <= '0;
            else
                tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // two stage sync, then a registered edge pulse
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            btn_s1   <= '0;
            btn_s2   <= '0;
            btn_s3   <= '0;
            btn_rise <= '0;
        end else begin
            btn_s1   <= btn;
            btn_s2   <= btn_s1;
            btn_s3   <= btn_s2;
            btn_rise <= btn_s2 & ~btn_s3;
        end
    end

    // power-on pulse shared by boost and reminder
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ms_prev       <= 1'b0;
            power_on_rise <= 1'b0;
        end else begin
            ms_prev       <= machine_state;
            power_on_rise <= machine_state & ~ms_prev;
        end
    end

endmodule

//--- src/disp_pkg.sv
package disp_pkg;

    localparam int DIGITS   = 8;
    localparam int DIGIT_W  = $clog2(DIGITS);
    localparam int SCAN_DIV = 4;                // clocks per digit
    localparam int SCAN_W   = $clog2(SCAN_DIV);

    localparam logic [3:0] SEP_CODE = 4'hf;     // drawn as a dash

    // display sources
    localparam logic [1:0] SRC_USAGE  = 2'd0;
    localparam logic [1:0] SRC_BOOST  = 2'd1;
    localparam logic [1:0] SRC_REMIND = 2'd2;

    // written field by field, scanned digit by digit
    typedef union packed {
        struct packed {
            logic [3:0] hr_tens;
            logic [3:0] hr_units;
            logic [3:0] sep_hm;
            logic [3:0] min_tens;
            logic [3:0] min_units;
            logic [3:0] sep_ms;
            logic [3:0] sec_tens;
            logic [3:0] sec_units;
        } fields;
        logic [DIGITS-1:0][3:0] digit;          // digit 7 is leftmost
    } disp_word_t;

    // segment bus is {dp, g, f, e, d, c, b, a}, active high
    function automatic logic [7:0] seg_lookup(input logic [3:0] code);
        case (code)
            4'd0:     return 8'h3f;
            4'd1:     return 8'h06;
            4'd2:     return 8'h5b;
            4'd3:     return 8'h4f;
            4'd4:     return 8'h66;
            4'd5:     return 8'h6d;
            4'd6:     return 8'h7d;
            4'd7:     return 8'h07;
            4'd8:     return 8'h7f;
            4'd9:     return 8'h6f;
            SEP_CODE: return 8'h40;             // middle bar only
            default:  return 8'h00;
        endcase
    endfunction

endpackage

//--- src/hood_pkg.sv
package hood_pkg;

    //////////////////////////////////////////////////
    // panel mode codes
    localparam logic [2:0] MODE_IDLE        = 3'd0;
    localparam logic [2:0] MODE_LOW         = 3'd1;
    localparam logic [2:0] MODE_HIGH        = 3'd2;
    localparam logic [2:0] MODE_BOOST       = 3'd3;
    localparam logic [2:0] MODE_SHOW_REMIND = 3'd5;

    // bit positions in the button vector
    localparam int BTN_UP    = 0;
    localparam int BTN_LEFT  = 1;
    localparam int BTN_RIGHT = 2;
    localparam int BTN_DOWN  = 3;

    //////////////////////////////////////////////////
    // timing
    localparam int TICK_DIV = 16;              // sim value, real board uses clock rate
    localparam int TICK_W   = $clog2(TICK_DIV);

    localparam int BOOST_MIN = 1;              // boost runs for one minute

    // time field limits and widths
    localparam int SEC_LIMIT       = 60;
    localparam int MIN_LIMIT       = 60;
    localparam int HR_LIMIT        = 24;
    localparam int REMIND_HR_RESET = 10;

    localparam int FIELD_W = 6;
    localparam int HR_W    = 5;
    localparam int TOTAL_W = 17;               // one day in seconds fits

endpackage
